/* run_sim.sh */
#!/usr/bin/env bash
# Build the control core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      -f sources.f --top-module tb_umtrx_ctrl -o sim_tb; then
   echo "Verilator build failed"
   exit 1
fi

if ! sim_out=$(./obj_dir/sim_tb 2>&1); then
   echo "$sim_out"
   echo "Simulation exited with an error status"
   exit 1
fi

echo "$sim_out"
if grep -q "^=== PASS ===$" <<< "$sim_out"; then
   exit 0
fi
exit 1

/* sim/tb_umtrx_ctrl.sv */
////////////////////
// Control core testbench with bus tasks, stimulus,
// assertions and report
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module tb_umtrx_ctrl import wb_pkg::*, ctrl_pkg::*; ();

   // Well above about 25 accesses of 3 cycles plus reset
   localparam int       TIMEOUT_CYCLES = 2000;
   localparam int       ACK_WAIT_MAX   = 8;
   localparam wb_addr_t RAM_ADR        = 16'h0010;
   localparam wb_addr_t BOOT_ADR       = 16'hC010;
   localparam wb_addr_t BAD_ADR        = 16'h9000;

   logic       wb_clk;
   logic       por_rst;
   wb_addr_t   wb_adr;
   wb_data_t   wb_dat_w;
   wb_sel_t    wb_sel;
   logic       wb_we;
   logic       wb_cyc;
   logic       wb_stb;
   wb_data_t   wb_dat_r;
   logic       wb_ack;
   logic       wb_err;
   logic       button;
   logic [1:0] aux_ld;
   logic [3:0] run_flags;
   wb_data_t   status;
   led_t       leds;
   logic [1:0] divsw;
   logic [1:0] lms_res;
   logic       phy_resetn;

   integer seed;
   int     cycle_cnt = 0;
   int     check_cnt = 0;
   int     fail_cnt = 0;
   int     test_cnt = 0;
   int     test_fail_base = 0;

   umtrx_ctrl_top uut (
      .wb_clk, .por_rst,
      .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_we_i(wb_we),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb),
      .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
      .button_i(button), .aux_ld_i(aux_ld), .run_flags_i(run_flags), .status_i(status),
      .leds_o(leds), .divsw_o(divsw), .lms_res_o(lms_res), .phy_resetn_o(phy_resetn)
   );

   initial begin
      wb_clk = 1'b0;
      forever #5 wb_clk = ~wb_clk;
   end

   always @(posedge wb_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   ////////////////////
   // Bus protocol

   a_resp_second_edge: assert property (
      @(posedge wb_clk) disable iff (por_rst) $rose(wb_stb) |=> (wb_ack || wb_err)
   ) else begin
      $display("%0d ns: access not answered on the second edge", $time);
      fail_cnt++;
   end

   a_resp_one_cycle: assert property (
      @(posedge wb_clk) disable iff (por_rst) (wb_ack || wb_err) |=> !(wb_ack || wb_err)
   ) else begin
      $display("%0d ns: ack or err held longer than one cycle", $time);
      fail_cnt++;
   end

   a_resp_needs_req: assert property (
      @(posedge wb_clk) disable iff (por_rst) (wb_ack || wb_err) |-> (wb_cyc && wb_stb)
   ) else begin
      $display("%0d ns: ack or err with no request", $time);
      fail_cnt++;
   end

   a_ack_xor_err: assert property (
      @(posedge wb_clk) disable iff (por_rst) !(wb_ack && wb_err)
   ) else begin
      $display("%0d ns: ack and err in the same cycle", $time);
      fail_cnt++;
   end

   ////////////////////
   // Helpers

   task automatic expect_eq(input string what, input wb_data_t got, input wb_data_t exp);
      check_cnt++;
      assert (got === exp) else begin
         $display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
         fail_cnt++;
      end
   endtask

   task automatic bus_access(input wb_addr_t adr, input logic we, input wb_data_t wdat,
                             output wb_data_t rdat, output logic got_err);
      int waited;
      waited = 0;
      @(posedge wb_clk);
      #1;
      wb_adr   = adr;
      wb_dat_w = wdat;
      wb_sel   = '1;
      wb_we    = we;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      // Response sampled mid-cycle
      do begin
         @(negedge wb_clk);
         waited++;
      end while (!wb_ack && !wb_err && waited < ACK_WAIT_MAX);
      if (!wb_ack && !wb_err) begin
         $display("%0d ns: no ack or err for access to %h", $time, adr);
         fail_cnt++;
      end
      rdat    = wb_dat_r;
      got_err = wb_err;
      @(posedge wb_clk);
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input wb_addr_t adr, input wb_data_t wdat);
      wb_data_t rdat;
      logic     got_err;
      bus_access(adr, 1'b1, wdat, rdat, got_err);
      expect_eq("err on write", 32'(got_err), 32'd0);
   endtask

   task automatic bus_read(input wb_addr_t adr, output wb_data_t rdat);
      logic got_err;
      bus_access(adr, 1'b0, '0, rdat, got_err);
      expect_eq("err on read", 32'(got_err), 32'd0);
   endtask

   task automatic drive_board(input logic btn, input logic [1:0] aux,
                              input logic [3:0] flags, input wb_data_t stat);
      @(posedge wb_clk);
      #1;
      button    = btn;
      aux_ld    = aux;
      run_flags = flags;
      status    = stat;
   endtask

   // One word per settings address in the window at 0x7000
   function automatic wb_addr_t set_adr(input int sr);
      return 16'h7000 + 16'(sr * 4);
   endfunction

   function automatic wb_addr_t rb_adr(input int word);
      return 16'h5C00 + 16'(word * 4);
   endfunction

   // Source bit 1 takes the run flag at bits 4:1, bit 0 takes the software value
   function automatic led_t expected_leds(input led_t src, input led_t sw,
                                          input logic [3:0] flags);
      led_t hw;
      led_t res;
      hw      = '0;
      hw[4:1] = flags;
      for (int b = 0; b < 8; b++) begin
         res[b] = src[b] ? hw[b] : sw[b];
      end
      return res;
   endfunction

   task automatic end_test(input string name);
      test_cnt++;
      if (fail_cnt == test_fail_base) begin
         $display("test %0d %s: ok", test_cnt, name);
      end else begin
         $display("test %0d %s: %0d failures", test_cnt, name, fail_cnt - test_fail_base);
      end
      test_fail_base = fail_cnt;
   endtask

   ////////////////////
   // Stimulus

   initial begin
      wb_data_t   ram_data;
      wb_data_t   rdat;
      wb_data_t   stat_val;
      wb_data_t   irq_exp;
      logic       got_err;
      led_t       led_val;
      led_t       led_src;
      logic [3:0] flags;
      int         waited;

      seed      = 32'h399a;
      por_rst   = 1'b1;
      wb_adr    = '0;
      wb_dat_w  = '0;
      wb_sel    = '0;
      wb_we     = 1'b0;
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      button    = 1'b0;
      aux_ld    = 2'b00;
      run_flags = 4'b1011;
      status    = '0;
      repeat (4) @(posedge wb_clk);
      #1;
      por_rst = 1'b0;
      // Bus reset drops one edge later
      @(posedge wb_clk);
      @(negedge wb_clk);

      expect_eq("leds_o", 32'(leds), 32'(expected_leds(8'h1E, 8'h00, run_flags)));
      expect_eq("divsw_o", 32'(divsw), 32'd3);
      expect_eq("lms_res_o", 32'(lms_res), 32'd0);
      expect_eq("phy_resetn_o", 32'(phy_resetn), 32'd1);
      end_test("reset values");

      ram_data = $random(seed);
      bus_write(RAM_ADR, ram_data);
      bus_read(RAM_ADR, rdat);
      expect_eq("read of 0x0010 in WAIT", rdat, ram_data);
      end_test("window swap before boot done");

      bus_write(set_adr(`UMTRX_SR_DIVSW), 32'd0);
      expect_eq("divsw_o after clear", 32'(divsw), 32'd2);
      bus_write(set_adr(`UMTRX_SR_MISC + `UMTRX_SR_BLDR), 32'd1);
      waited = 0;
      while (divsw != 2'b11 && waited < ACK_WAIT_MAX) begin
         @(negedge wb_clk);
         waited++;
      end
      if (divsw != 2'b11) begin
         $display("%0d ns: no bus reset seen after bootloader done", $time);
      end
      expect_eq("divsw_o after boot done", 32'(divsw), 32'd3);
      end_test("bus reset after boot done");

      bus_read(BOOT_ADR, rdat);
      expect_eq("read of 0xC010 in DONE", rdat, ram_data);
      end_test("window swap after boot done");

      // All software, all hardware, then a random source mix
      for (int i = 0; i < 3; i++) begin
         led_val = 8'($random(seed));
         flags   = 4'($random(seed));
         led_src = (i == 0) ? 8'h00 : (i == 1) ? 8'hFF : 8'($random(seed));
         bus_write(set_adr(`UMTRX_SR_MISC + `UMTRX_SR_LED), 32'(led_val));
         bus_write(set_adr(`UMTRX_SR_MISC + `UMTRX_SR_LED_SRC), 32'(led_src));
         drive_board(1'b0, 2'b00, flags, '0);
         @(negedge wb_clk);
         expect_eq("leds_o", 32'(leds), 32'(expected_leds(led_src, led_val, flags)));
      end
      end_test("led mix");

      for (int i = 0; i < 2; i++) begin
         stat_val = $random(seed);
         drive_board(1'(i), 2'(i + 1), 4'b0000, stat_val);
         // Major 9 in the upper half, minor 0 in the lower
         bus_read(rb_adr(12), rdat);
         expect_eq("compat number", rdat, 32'h0009_0000);
         bus_read(rb_adr(8), rdat);
         expect_eq("status word", rdat, stat_val);
         irq_exp        = '0;
         irq_exp[17:16] = 2'(i + 1);
         irq_exp[15]    = 1'(i);
         bus_read(rb_adr(13), rdat);
         expect_eq("irq word", rdat, irq_exp);
      end
      end_test("readback words");

      bus_access(BAD_ADR, 1'b0, '0, rdat, got_err);
      expect_eq("err on read of 0x9000", 32'(got_err), 32'd1);
      bus_access(BAD_ADR, 1'b1, ram_data, rdat, got_err);
      expect_eq("err on write of 0x9000", 32'(got_err), 32'd1);
      // Readback ignores writes
      bus_write(rb_adr(12), ram_data);
      bus_read(rb_adr(12), rdat);
      expect_eq("compat number after write", rdat, 32'h0009_0000);
      end_test("bus rules");

      $display("tests: %0d, checks: %0d, failures: %0d", test_cnt, check_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/ctrl_pkg.sv
verilog/wb_if.sv
verilog/boot_reset_ctrl.sv
verilog/wb_decoder.sv
verilog/wb_ram.sv
verilog/setting_reg.sv
verilog/ctrl_regs.sv
verilog/readback_mux.sv
verilog/umtrx_ctrl_top.sv
sim/tb_umtrx_ctrl.sv

/* verilog/boot_reset_ctrl.sv */
////////////////////
// Boot state, bus reset pulse, RAM window swap
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module boot_reset_ctrl import wb_pkg::*, ctrl_pkg::*; (
   input  logic     wb_clk,
   input  logic     por_rst,
   input  logic     bldr_done_i,
   input  wb_addr_t cpu_adr_i,
   output wb_addr_t wb_adr_o,
   output logic     wb_rst_o
);

   localparam wb_addr_t SWAP_MASK = {2'b11, {(`UMTRX_AW-2){1'b0}}};

   boot_state_e state;
   logic        keep_adr;

   // wb_rst stays high one cycle past por_rst, and pulses once on boot done
   always_ff @(posedge wb_clk) begin
      if (por_rst) begin
         state    <= WAIT;
         wb_rst_o <= 1'b1;
      end else begin
         wb_rst_o <= 1'b0;
         if (state == WAIT && bldr_done_i) begin
            state    <= DONE;
            wb_rst_o <= 1'b1;
         end
      end
   end

   // In WAIT the 00 and 11 quarters trade places
   assign keep_adr = (^cpu_adr_i[`UMTRX_AW-1 -: 2]) || (state == DONE);
   assign wb_adr_o = keep_adr ? cpu_adr_i : (cpu_adr_i ^ SWAP_MASK);

   ////////////////////
   // Checks

   a_rst_single_pulse: assert property (
      @(posedge wb_clk) disable iff (por_rst)
      wb_rst_o |=> !wb_rst_o
   ) else $error("bus reset held for more than one cycle");

endmodule

/* verilog/ctrl_pkg.sv */
////////////////////
// Boot state, LED byte and settings bus types
////////////////////
`include "umtrx_cfg.svh"

package ctrl_pkg;

   typedef enum logic {
      WAIT,
      DONE
   } boot_state_e;

   typedef logic [7:0] led_t;

   // One settings bus write
   typedef struct packed {
      logic                 stb;
      logic [7:0]           addr;
      logic [`UMTRX_DW-1:0] data;
   } set_bus_t;

endpackage

/* verilog/ctrl_regs.sv */
////////////////////
// Settings bus slave, control registers, LED mix
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module ctrl_regs import wb_pkg::*, ctrl_pkg::*; (
   input  logic       wb_clk,
   input  logic       wb_rst_i,
   wb_if.slave        bus,
   input  logic [3:0] run_flags_i,
   output led_t       leds_o,
   output logic [1:0] divsw_o,
   output logic [1:0] lms_res_o,
   output logic       phy_resetn_o,
   output logic       bldr_done_o,
   output wb_data_t   set_copy_o
);

   logic         ack_q;
   logic         req;
   logic         set_stb_q;
   logic [7:0]   set_addr_q;
   wb_data_t     set_data_q;
   set_bus_t     set_bus;
   led_t         led_sw;
   led_t         led_src;
   led_t         led_hw;
   logic         phy_reset;

   ////////////////////
   // Wishbone to settings strobe

   assign req = bus.cyc & bus.stb & ~ack_q;

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         ack_q     <= req;
         set_stb_q <= req & bus.we;
      end
   end

   // Word address inside the window
   always_ff @(posedge wb_clk) begin
      set_addr_q <= bus.adr[9:2];
      set_data_q <= bus.dat_w;
   end

   assign set_bus   = '{stb: set_stb_q, addr: set_addr_q, data: set_data_q};
   assign bus.ack   = ack_q;
   assign bus.dat_r = '0;

   ////////////////////
   // Registers

   setting_reg #(.T(led_t), .ADDR(`UMTRX_SR_MISC + `UMTRX_SR_LED), .RESET_VAL(8'h00))
      sr_led (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(led_sw));

   setting_reg #(.T(led_t), .ADDR(`UMTRX_SR_MISC + `UMTRX_SR_LED_SRC),
                 .RESET_VAL(`UMTRX_LED_SRC_RST))
      sr_led_src (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(led_src));

   // Both switches come up closed
   setting_reg #(.T(logic), .ADDR(`UMTRX_SR_DIVSW + 0), .RESET_VAL(1'b1))
      sr_divsw0 (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(divsw_o[0]));

   setting_reg #(.T(logic), .ADDR(`UMTRX_SR_DIVSW + 1), .RESET_VAL(1'b1))
      sr_divsw1 (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(divsw_o[1]));

   setting_reg #(.T(logic [1:0]), .ADDR(`UMTRX_SR_MISC + `UMTRX_SR_LMS_RES),
                 .RESET_VAL(2'b00))
      sr_lms_res (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(lms_res_o));

   setting_reg #(.T(logic), .ADDR(`UMTRX_SR_MISC + `UMTRX_SR_PHY), .RESET_VAL(1'b0))
      sr_phy (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(phy_reset));

   setting_reg #(.T(logic), .ADDR(`UMTRX_SR_MISC + `UMTRX_SR_BLDR), .RESET_VAL(1'b0))
      sr_bldr (.wb_clk, .wb_rst_i, .set_i(set_bus), .val_o(bldr_done_o));

   assign phy_resetn_o = ~phy_reset;

   // Readback copy with lms_res at 1:0, phy at 4 and divsw at 9:8
   assign set_copy_o = {{(`UMTRX_DW-10){1'b0}}, divsw_o, 3'b000, phy_reset, 2'b00, lms_res_o};

   ////////////////////
   // Source bit 1 selects the hardware LED
   assign led_hw = {3'b000, run_flags_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

/* verilog/readback_mux.sv */
////////////////////
// Sixteen-word readback slave
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module readback_mux import wb_pkg::*; (
   input logic       wb_clk,
   input logic       wb_rst_i,
   wb_if.slave       bus,
   input wb_data_t   status_i,
   input wb_data_t   set_copy_i,
   input logic       button_i,
   input logic [1:0] aux_ld_i
);

   logic     ack_q;
   logic     req;
   wb_data_t word_sel;
   wb_data_t irq_rb;
   wb_data_t dat_q;

   assign req = bus.cyc & bus.stb & ~ack_q;

   // aux lock detect at 17:16, button at 15
   assign irq_rb = {14'd0, aux_ld_i, button_i, 15'd0};

   always_comb begin
      case (bus.adr[5:2])
         4'd0:    word_sel = set_copy_i;
         4'd8:    word_sel = status_i;
         4'd12:   word_sel = `UMTRX_COMPAT_NUM;
         4'd13:   word_sel = irq_rb;
         default: word_sel = '0;
      endcase
   end

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   // Writes get an ack and are dropped
   always_ff @(posedge wb_clk) begin
      dat_q <= word_sel;
   end

   assign bus.ack   = ack_q;
   assign bus.dat_r = dat_q;

endmodule

/* verilog/setting_reg.sv */
////////////////////
// One settings bus register
////////////////////
`timescale 1ns/1ps

module setting_reg import ctrl_pkg::*; #(
   parameter type T         = logic,
   parameter int  ADDR      = 0,
   parameter T    RESET_VAL = '0
) (
   input  logic     wb_clk,
   input  logic     wb_rst_i,
   input  set_bus_t set_i,
   output T         val_o
);

   // Takes the low bits of the data word
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         val_o <= RESET_VAL;
      end else if (set_i.stb && set_i.addr == 8'(ADDR)) begin
         val_o <= T'(set_i.data[$bits(T)-1:0]);
      end
   end

endmodule

/* verilog/umtrx_cfg.svh */
////////////////////
// Bus widths, Wishbone memory map, settings addresses
// and reset values for the control core
////////////////////
`ifndef UMTRX_CFG_SVH
`define UMTRX_CFG_SVH

`define UMTRX_DW        32
`define UMTRX_AW        16
`define UMTRX_SW        4
`define UMTRX_DECODE_W  8
`define UMTRX_RAM_AW    12

// Decoder windows on the top address byte
`define UMTRX_MAIN_RAM_BASE  8'h00
`define UMTRX_MAIN_RAM_MASK  8'hC0
`define UMTRX_READBACK_BASE  8'h5C
`define UMTRX_READBACK_MASK  8'hFC
`define UMTRX_SETTINGS_BASE  8'h70
`define UMTRX_SETTINGS_MASK  8'hF0
`define UMTRX_BOOT_RAM_BASE  8'hC0
`define UMTRX_BOOT_RAM_MASK  8'hC0

// Settings bus word addresses
`define UMTRX_SR_MISC     0
`define UMTRX_SR_LMS_RES  0
`define UMTRX_SR_LED      3
`define UMTRX_SR_PHY      4
`define UMTRX_SR_BLDR     5
`define UMTRX_SR_LED_SRC  6
`define UMTRX_SR_DIVSW    180

`define UMTRX_LED_SRC_RST 8'h1E
// Major in the upper half, minor in the lower half
`define UMTRX_COMPAT_NUM  {16'd9, 16'd0}

`endif

/* verilog/umtrx_ctrl_top.sv */
////////////////////
// Control core top with boot control, decoder, RAMs,
// settings registers and readback
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module umtrx_ctrl_top import wb_pkg::*, ctrl_pkg::*; (
   input  logic       wb_clk,
   input  logic       por_rst,
   // Wishbone master port
   input  wb_addr_t   wb_adr_i,
   input  wb_data_t   wb_dat_i,
   input  wb_sel_t    wb_sel_i,
   input  logic       wb_we_i,
   input  logic       wb_cyc_i,
   input  logic       wb_stb_i,
   output wb_data_t   wb_dat_o,
   output logic       wb_ack_o,
   output logic       wb_err_o,
   // Board status and control
   input  logic       button_i,
   input  logic [1:0] aux_ld_i,
   input  logic [3:0] run_flags_i,
   input  wb_data_t   status_i,
   output led_t       leds_o,
   output logic [1:0] divsw_o,
   output logic [1:0] lms_res_o,
   output logic       phy_resetn_o
);

   logic     wb_rst;
   logic     bldr_done;
   wb_addr_t bus_adr;
   wb_data_t set_copy;

   wb_if slv_if [WB_NUM_SLAVES] ();

   boot_reset_ctrl u_boot (
      .wb_clk, .por_rst,
      .bldr_done_i(bldr_done), .cpu_adr_i(wb_adr_i),
      .wb_adr_o(bus_adr), .wb_rst_o(wb_rst)
   );

   wb_decoder u_dec (
      .wb_clk, .wb_rst_i(wb_rst),
      .adr_i(bus_adr), .dat_i(wb_dat_i), .sel_i(wb_sel_i), .we_i(wb_we_i),
      .cyc_i(wb_cyc_i), .stb_i(wb_stb_i),
      .dat_o(wb_dat_o), .ack_o(wb_ack_o), .err_o(wb_err_o),
      .slv(slv_if)
   );

   ////////////////////
   // Slaves

   wb_ram #(.DEPTH_AW(`UMTRX_RAM_AW)) u_main_ram (
      .wb_clk, .wb_rst_i(wb_rst), .bus(slv_if[MAIN_RAM])
   );

   wb_ram #(.DEPTH_AW(`UMTRX_RAM_AW)) u_boot_ram (
      .wb_clk, .wb_rst_i(wb_rst), .bus(slv_if[BOOT_RAM])
   );

   readback_mux u_rb (
      .wb_clk, .wb_rst_i(wb_rst), .bus(slv_if[READBACK]),
      .status_i, .set_copy_i(set_copy), .button_i, .aux_ld_i
   );

   ctrl_regs u_regs (
      .wb_clk, .wb_rst_i(wb_rst), .bus(slv_if[SETTINGS]),
      .run_flags_i, .leds_o, .divsw_o, .lms_res_o, .phy_resetn_o,
      .bldr_done_o(bldr_done), .set_copy_o(set_copy)
   );

endmodule

/* verilog/wb_decoder.sv */
////////////////////
// Single-master Wishbone decoder for four slaves
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module wb_decoder import wb_pkg::*; (
   input  logic     wb_clk,
   input  logic     wb_rst_i,
   input  wb_addr_t adr_i,
   input  wb_data_t dat_i,
   input  wb_sel_t  sel_i,
   input  logic     we_i,
   input  logic     cyc_i,
   input  logic     stb_i,
   output wb_data_t dat_o,
   output logic     ack_o,
   output logic     err_o,
   wb_if.master     slv [WB_NUM_SLAVES]
);

   // Index 0 is MAIN_RAM in enum order
   localparam logic [WB_NUM_SLAVES-1:0][`UMTRX_DECODE_W-1:0] BASES = {
      `UMTRX_BOOT_RAM_BASE, `UMTRX_SETTINGS_BASE,
      `UMTRX_READBACK_BASE, `UMTRX_MAIN_RAM_BASE};
   localparam logic [WB_NUM_SLAVES-1:0][`UMTRX_DECODE_W-1:0] MASKS = {
      `UMTRX_BOOT_RAM_MASK, `UMTRX_SETTINGS_MASK,
      `UMTRX_READBACK_MASK, `UMTRX_MAIN_RAM_MASK};

   logic [`UMTRX_DECODE_W-1:0] top_adr;
   logic [WB_NUM_SLAVES-1:0]   hit;
   logic [WB_NUM_SLAVES-1:0]   slv_stb;
   logic [WB_NUM_SLAVES-1:0]   slv_ack;
   wb_data_t                   slv_dat [WB_NUM_SLAVES];
   logic                       err_q;

   assign top_adr = adr_i[`UMTRX_AW-1 -: `UMTRX_DECODE_W];

   for (genvar i = 0; i < WB_NUM_SLAVES; i++) begin : g_slv
      assign hit[i]       = ((top_adr ^ BASES[i]) & MASKS[i]) == '0;
      assign slv[i].adr   = adr_i;
      assign slv[i].dat_w = dat_i;
      assign slv[i].sel   = sel_i;
      assign slv[i].we    = we_i;
      assign slv[i].cyc   = cyc_i & hit[i];
      assign slv[i].stb   = stb_i & hit[i];
      assign slv_stb[i]   = slv[i].stb;
      assign slv_ack[i]   = slv[i].ack;
      assign slv_dat[i]   = slv[i].dat_r;
   end

   // Return path from the selected slave
   always_comb begin
      dat_o = '0;
      for (int i = 0; i < WB_NUM_SLAVES; i++) begin
         if (hit[i]) begin
            dat_o = slv_dat[i];
         end
      end
   end

   assign ack_o = |slv_ack;

   // One-cycle error for an unmapped address
   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= cyc_i & stb_i & ~(|hit) & ~err_q;
      end
   end

   assign err_o = err_q;

   a_one_slave: assert property (
      @(posedge wb_clk) disable iff (wb_rst_i)
      $onehot0(slv_stb) && (!ack_o || |(slv_ack & slv_stb))
   ) else $error("more than one slave strobed, or ack from an unselected slave");

endmodule

/* verilog/wb_if.sv */
////////////////////
// Wishbone slave link
////////////////////
`timescale 1ns/1ps

interface wb_if import wb_pkg::*; ();

   wb_addr_t adr;
   wb_data_t dat_w;
   wb_data_t dat_r;
   wb_sel_t  sel;
   logic     we;
   logic     cyc;
   logic     stb;
   logic     ack;

   // Decoder side
   modport master (
      output adr, dat_w, sel, we, cyc, stb,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, sel, we, cyc, stb,
      output dat_r, ack
   );

endinterface

/* verilog/wb_pkg.sv */
////////////////////
// Wishbone bus types and slave index
////////////////////
`include "umtrx_cfg.svh"

package wb_pkg;

   typedef logic [`UMTRX_AW-1:0] wb_addr_t;
   typedef logic [`UMTRX_DW-1:0] wb_data_t;
   typedef logic [`UMTRX_SW-1:0] wb_sel_t;

   // Slave order on the decoder
   typedef enum logic [1:0] {
      MAIN_RAM,
      READBACK,
      SETTINGS,
      BOOT_RAM
   } wb_slave_e;

   localparam int WB_NUM_SLAVES = 4;

endpackage

/* verilog/wb_ram.sv */
////////////////////
// Single-port Wishbone RAM, byte writes
////////////////////
`timescale 1ns/1ps
`include "umtrx_cfg.svh"

module wb_ram import wb_pkg::*; #(
   parameter int DEPTH_AW = `UMTRX_RAM_AW
) (
   input logic wb_clk,
   input logic wb_rst_i,
   wb_if.slave bus
);

   wb_data_t            mem [2**DEPTH_AW];
   wb_data_t            rd_q;
   logic                ack_q;
   logic                req;
   logic [DEPTH_AW-1:0] word_adr;

   assign req      = bus.cyc & bus.stb & ~ack_q & ~wb_rst_i;
   assign word_adr = bus.adr[DEPTH_AW+1:2];

   always_ff @(posedge wb_clk) begin
      if (wb_rst_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= req;
      end
   end

   // Read data lands with ack
   always_ff @(posedge wb_clk) begin
      if (req && bus.we) begin
         for (int b = 0; b < `UMTRX_SW; b++) begin
            if (bus.sel[b]) begin
               mem[word_adr][8*b +: 8] <= bus.dat_w[8*b +: 8];
            end
         end
      end
      rd_q <= mem[word_adr];
   end

   assign bus.dat_r = rd_q;
   assign bus.ack   = ack_q;

   a_ack_after_stb: assert property (
      @(posedge wb_clk) disable iff (wb_rst_i)
      bus.ack |-> (bus.cyc && bus.stb)
   ) else $error("RAM ack without a request");

endmodule
